//--- rtl/pipe_settings.svh
`ifndef PIPE_SETTINGS_SVH
`define PIPE_SETTINGS_SVH

// mask width
// bit 0 is PC, then IF_ID, ID_EX, EX_MEM, MEM_WB and a spare top bit
`define PIPE_STAGES 6

// total cycles a mul/div keeps EX occupied
// the start cycle counts as the first one
`define MULDIV_CYCLES 4

`endif

//--- rtl/pipe_ctrl_pkg.sv
`include "pipe_settings.svh"

package pipe_ctrl_pkg;

  // one bit per pipeline register, bit 0 is the PC
  typedef logic [`PIPE_STAGES-1:0] stage_mask_t;

  typedef struct packed {
    stage_mask_t stall;  // hold the register
    stage_mask_t flush;  // insert a bubble
  } ctrl_mask_t;

  // request levels into the controller
  // listed from the highest priority down
  typedef struct packed {
    logic ram_mem;     // data memory access pending
    logic ram_if;      // instruction memory access pending
    logic trap_flush;  // ecall or exception taken
    logic trap_stall;  // csr side effect in progress
    logic jump;        // taken branch or jump in EX
    logic muldiv;      // multi-cycle op occupies EX
    logic load_use;    // ID needs a load result from EX
    logic if_wait;     // instruction read not yet returned
  } hazard_req_t;

endpackage

//--- rtl/pipe_isa_pkg.sv
package pipe_isa_pkg;

  localparam logic [6:0] OPC_LOAD = 7'b0000011;
  localparam logic [6:0] OPC_OP   = 7'b0110011;  // register-register alu op

  typedef logic [4:0] reg_idx_t;

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    logic [6:0] opcode;
  } r_type_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    logic [6:0]  opcode;
  } i_type_t;

  // same 32-bit word, two field layouts
  // opcode, rd and rs1 line up in both views
  typedef union packed {
    r_type_t r;
    i_type_t i;
  } instr_u;

endpackage

//--- rtl/load_use_detect.sv
`timescale 1ns/1ps

module load_use_detect (
  input  pipe_isa_pkg::instr_u id_instr_i,
  input  pipe_isa_pkg::instr_u ex_instr_i,
  input  logic                 ex_valid_i,
  output logic                 load_use_o
);

  import pipe_isa_pkg::*;

  reg_idx_t ex_rd;
  logic     ex_is_load;
  logic     id_uses_rs2;
  logic     rs1_hit;
  logic     rs2_hit;

  // EX side through the I-type view
  assign ex_rd      = ex_instr_i.i.rd;
  assign ex_is_load = ex_valid_i && (ex_instr_i.i.opcode == OPC_LOAD);

  // ID side through the R-type view
  // rs2 only counts for a register-register op
  assign id_uses_rs2 = (id_instr_i.r.opcode == OPC_OP);

  assign rs1_hit = (id_instr_i.r.rs1 == ex_rd);
  assign rs2_hit = id_uses_rs2 && (id_instr_i.r.rs2 == ex_rd);

  // x0 never carries a dependency
  assign load_use_o = ex_is_load && (ex_rd != '0) && (rs1_hit || rs2_hit);

endmodule

//--- rtl/muldiv_busy.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module muldiv_busy (
  input  logic clk,
  input  logic rst,
  input  logic muldiv_start_i,
  output logic busy_o
);

  localparam int CNT_W = (`MULDIV_CYCLES > 1) ? $clog2(`MULDIV_CYCLES) : 1;

  // remaining cycles after the start cycle
  localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`MULDIV_CYCLES - 1);

  logic [CNT_W-1:0] cnt_q;
  logic             idle;

  assign idle = (cnt_q == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (muldiv_start_i && idle) begin
      cnt_q <= CNT_LOAD;  // new op accepted
    end else if (!idle) begin
      cnt_q <= cnt_q - 1'b1;  // a start here is dropped
    end
  end

  // busy already in the strobe cycle
  assign busy_o = muldiv_start_i || !idle;

endmodule

//--- rtl/pipeline_control.sv
`timescale 1ns/1ps

module pipeline_control (
  input  logic                      rst,
  input  pipe_ctrl_pkg::hazard_req_t req_i,
  output pipe_ctrl_pkg::ctrl_mask_t  ctrl_o
);

  import pipe_ctrl_pkg::*;

  // masks from bit 5 down to bit 0 (PC)
  localparam stage_mask_t MASK_NONE = 6'b000000;

  localparam stage_mask_t RST_FLUSH = 6'b011111;

  localparam stage_mask_t RAM_MEM_STALL = 6'b001111;
  localparam stage_mask_t RAM_MEM_FLUSH = 6'b010000;  // bubble into MEM_WB

  localparam stage_mask_t RAM_IF_STALL = 6'b001111;

  localparam stage_mask_t TRAP_FLUSH_STALL = 6'b000010;
  localparam stage_mask_t TRAP_FLUSH_FLUSH = 6'b001110;

  localparam stage_mask_t TRAP_STALL_STALL = 6'b111111;  // freeze everything
  localparam stage_mask_t TRAP_STALL_FLUSH = 6'b001110;

  // taken jump while the fetch is still outstanding
  localparam stage_mask_t JUMP_WAIT_STALL = 6'b000111;
  localparam stage_mask_t JUMP_WAIT_FLUSH = 6'b001000;

  localparam stage_mask_t JUMP_STALL = 6'b000010;
  localparam stage_mask_t JUMP_FLUSH = 6'b000110;  // squash wrong-path IF and ID

  localparam stage_mask_t MULDIV_STALL = 6'b000111;
  localparam stage_mask_t MULDIV_FLUSH = 6'b001000;

  localparam stage_mask_t LOAD_USE_STALL = 6'b000011;
  localparam stage_mask_t LOAD_USE_FLUSH = 6'b000100;  // bubble into ID_EX

  localparam stage_mask_t IF_WAIT_STALL = 6'b000111;

  // later stages win
  always_comb begin
    if (rst) begin
      ctrl_o.stall = MASK_NONE;
      ctrl_o.flush = RST_FLUSH;
    end else if (req_i.ram_mem) begin
      ctrl_o.stall = RAM_MEM_STALL;
      ctrl_o.flush = RAM_MEM_FLUSH;
    end else if (req_i.ram_if) begin
      ctrl_o.stall = RAM_IF_STALL;
      ctrl_o.flush = MASK_NONE;
    end else if (req_i.trap_flush) begin
      ctrl_o.stall = TRAP_FLUSH_STALL;
      ctrl_o.flush = TRAP_FLUSH_FLUSH;
    end else if (req_i.trap_stall) begin
      ctrl_o.stall = TRAP_STALL_STALL;
      ctrl_o.flush = TRAP_STALL_FLUSH;
    end else if (req_i.jump && req_i.if_wait) begin
      ctrl_o.stall = JUMP_WAIT_STALL;
      ctrl_o.flush = JUMP_WAIT_FLUSH;
    end else if (req_i.jump) begin
      ctrl_o.stall = JUMP_STALL;
      ctrl_o.flush = JUMP_FLUSH;
    end else if (req_i.muldiv) begin
      ctrl_o.stall = MULDIV_STALL;
      ctrl_o.flush = MULDIV_FLUSH;
    end else if (req_i.load_use) begin
      ctrl_o.stall = LOAD_USE_STALL;
      ctrl_o.flush = LOAD_USE_FLUSH;
    end else if (req_i.if_wait) begin
      ctrl_o.stall = IF_WAIT_STALL;  // hold the front end only
      ctrl_o.flush = MASK_NONE;
    end else begin
      ctrl_o.stall = MASK_NONE;
      ctrl_o.flush = MASK_NONE;
    end
  end

endmodule

//--- rtl/stage_valid_track.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module stage_valid_track (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      fetch_valid_i,
  input  pipe_ctrl_pkg::ctrl_mask_t  ctrl_i,
  output pipe_ctrl_pkg::stage_mask_t valid_o
);

  import pipe_ctrl_pkg::*;

  stage_mask_t valid_q;
  stage_mask_t upstream;  // what each register would take on advance
  stage_mask_t valid_d;

  assign upstream = {valid_q[`PIPE_STAGES-2:0], fetch_valid_i};

  // flush over stall over advance
  always_comb begin
    for (int k = 0; k < `PIPE_STAGES; k++) begin
      if (ctrl_i.flush[k]) begin
        valid_d[k] = 1'b0;
      end else if (ctrl_i.stall[k]) begin
        valid_d[k] = valid_q[k];
      end else begin
        valid_d[k] = upstream[k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      valid_q <= valid_d;
    end
  end

  assign valid_o = valid_q;

endmodule

//--- rtl/hazard_top.sv
`timescale 1ns/1ps

module hazard_top (
  input  logic                       clk,
  input  logic                       rst,
  input  logic                       ram_stall_mem_i,
  input  logic                       ram_stall_if_i,
  input  logic                       trap_flush_i,
  input  logic                       trap_stall_i,
  input  logic                       jump_i,
  input  logic                       if_wait_i,
  input  logic                       fetch_valid_i,
  input  logic                       muldiv_start_i,
  input  logic                       ex_valid_i,
  input  pipe_isa_pkg::instr_u       id_instr_i,
  input  pipe_isa_pkg::instr_u       ex_instr_i,
  output pipe_ctrl_pkg::ctrl_mask_t  ctrl_o,
  output pipe_ctrl_pkg::stage_mask_t valid_o
);

  import pipe_ctrl_pkg::*;

  hazard_req_t req;
  ctrl_mask_t  ctrl;
  logic        load_use;
  logic        muldiv_busy_w;

  // pack external levels with the locally produced hazards
  assign req.ram_mem    = ram_stall_mem_i;
  assign req.ram_if     = ram_stall_if_i;
  assign req.trap_flush = trap_flush_i;
  assign req.trap_stall = trap_stall_i;
  assign req.jump       = jump_i;
  assign req.muldiv     = muldiv_busy_w;
  assign req.load_use   = load_use;
  assign req.if_wait    = if_wait_i;

  load_use_detect u_load_use (
    .id_instr_i (id_instr_i),
    .ex_instr_i (ex_instr_i),
    .ex_valid_i (ex_valid_i),
    .load_use_o (load_use)
  );

  muldiv_busy u_muldiv (
    .clk            (clk),
    .rst            (rst),
    .muldiv_start_i (muldiv_start_i),
    .busy_o         (muldiv_busy_w)
  );

  pipeline_control u_ctrl (
    .rst    (rst),
    .req_i  (req),
    .ctrl_o (ctrl)
  );

  stage_valid_track u_valid (
    .clk           (clk),
    .rst           (rst),
    .fetch_valid_i (fetch_valid_i),
    .ctrl_i        (ctrl),
    .valid_o       (valid_o)
  );

  assign ctrl_o = ctrl;

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS  = 40,
  parameter int RST_CYCLES = 8
) (
  output logic clk_o,
  output logic rst_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // released on a rising edge, like any other driven input
  initial begin
    rst_o = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_o);
    rst_o <= 1'b0;
  end

endmodule

//--- dv/hazard_props.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module hazard_props (
  input logic                       clk_i,
  input logic                       rst_i,
  input pipe_ctrl_pkg::hazard_req_t req_i,
  input logic                       start_i,
  input logic                       busy_i,
  input pipe_ctrl_pkg::ctrl_mask_t  ctrl_i,
  input pipe_ctrl_pkg::stage_mask_t valid_i
);

  logic overlap_allowed;

  // trap and plain jump masks stall the IF_ID bit they also flush
  assign overlap_allowed = req_i.trap_flush || req_i.trap_stall || req_i.jump;

  no_stall_flush_overlap: assert property (@(posedge clk_i) disable iff (rst_i)
    !overlap_allowed |-> (ctrl_i.stall & ctrl_i.flush) == '0)
    else $error("stall and flush both set for one stage");

  flushed_stage_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    (ctrl_i.flush != '0) |=> (valid_i & $past(ctrl_i.flush)) == '0)
    else $error("flushed stage still valid one cycle later");

  // only a new start may keep busy up past the op length
  busy_bounded: assert property (@(posedge clk_i) disable iff (rst_i)
    $rose(busy_i) |-> ##(`MULDIV_CYCLES) (!busy_i || start_i))
    else $error("mul/div busy held longer than its op length");

endmodule

bind hazard_top hazard_props u_props (
  .clk_i   (clk),
  .rst_i   (rst),
  .req_i   (req),
  .start_i (muldiv_start_i),
  .busy_i  (muldiv_busy_w),
  .ctrl_i  (ctrl),
  .valid_i (valid_o)
);

//--- dv/hazard_tb.sv
`timescale 1ns/1ps
`include "pipe_settings.svh"

module hazard_tb;

  import pipe_ctrl_pkg::*;
  import pipe_isa_pkg::*;

  localparam int RST_CYCLES  = 8;
  localparam int MD_LEN      = 400;
  localparam int LU_LEN      = 500;
  localparam int RAND_LEN    = 2000;
  localparam int CYCLE_LIMIT = RST_CYCLES + 2 + MD_LEN + LU_LEN + RAND_LEN + 50;

  logic        clk;
  logic        rst;
  logic        ram_stall_mem, ram_stall_if, trap_flush, trap_stall, jump, if_wait;
  logic        fetch_valid, muldiv_start, ex_valid;
  instr_u      id_instr, ex_instr;
  ctrl_mask_t  ctrl;
  stage_mask_t valid;

  logic [15:0] lfsr;
  int          cycle_cnt;
  int          checks, errors, t_checks, t_errors, tests_run;
  string       test_name;
  int          m_cnt;    // model of the mul/div down-counter
  stage_mask_t m_valid;  // model of the occupancy register

  tb_clk_gen #(.PERIOD_NS(40), .RST_CYCLES(RST_CYCLES)) u_clk (.clk_o(clk), .rst_o(rst));

  hazard_top dut (
    .clk             (clk),
    .rst             (rst),
    .ram_stall_mem_i (ram_stall_mem),
    .ram_stall_if_i  (ram_stall_if),
    .trap_flush_i    (trap_flush),
    .trap_stall_i    (trap_stall),
    .jump_i          (jump),
    .if_wait_i       (if_wait),
    .fetch_valid_i   (fetch_valid),
    .muldiv_start_i  (muldiv_start),
    .ex_valid_i      (ex_valid),
    .id_instr_i      (id_instr),
    .ex_instr_i      (ex_instr),
    .ctrl_o          (ctrl),
    .valid_o         (valid)
  );

  // x^16 + x^14 + x^13 + x^11 feedback stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int b = 0; b < n; b++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  // only x0..x3 so register matches are frequent
  function automatic instr_u rand_instr();
    logic [1:0] sel;
    logic [6:0] opc;
    logic [4:0] rs1, rs2, rd;
    sel = next_bits(2);
    opc = (sel == 2'd0) ? OPC_LOAD : (sel == 2'd1) ? OPC_OP : 7'b0010011;
    rd  = next_bits(2);
    rs1 = next_bits(2);
    rs2 = next_bits(2);
    return {7'b0000000, rs2, rs1, 3'b010, rd, opc};
  endfunction

  function automatic logic model_load_use(input logic [31:0] id_w, input logic [31:0] ex_w,
                                          input logic ex_v);
    logic [4:0] rd;
    logic       hit;
    rd  = ex_w[11:7];
    hit = (id_w[19:15] == rd) || ((id_w[6:0] == OPC_OP) && (id_w[24:20] == rd));
    return ex_v && (ex_w[6:0] == OPC_LOAD) && (rd != 5'd0) && hit;
  endfunction

  // {stall, flush} straight from the priority table
  function automatic ctrl_mask_t model_ctrl(input logic in_rst, input hazard_req_t r);
    if (in_rst) return {6'b000000, 6'b011111};
    if (r.ram_mem) return {6'b001111, 6'b010000};
    if (r.ram_if) return {6'b001111, 6'b000000};
    if (r.trap_flush) return {6'b000010, 6'b001110};
    if (r.trap_stall) return {6'b111111, 6'b001110};
    if (r.jump && r.if_wait) return {6'b000111, 6'b001000};
    if (r.jump) return {6'b000010, 6'b000110};
    if (r.muldiv) return {6'b000111, 6'b001000};
    if (r.load_use) return {6'b000011, 6'b000100};
    if (r.if_wait) return {6'b000111, 6'b000000};
    return '0;
  endfunction

  task automatic check_ctrl(input ctrl_mask_t exp, input ctrl_mask_t act);
    checks++;
    t_checks++;
    if (act !== exp) begin
      errors++;
      t_errors++;
      $display("Fail %s: ctrl expected stall=%b flush=%b, actual stall=%b flush=%b",
               test_name, exp.stall, exp.flush, act.stall, act.flush);
    end
  endtask

  task automatic check_valid(input stage_mask_t exp, input stage_mask_t act);
    checks++;
    t_checks++;
    if (act !== exp) begin
      errors++;
      t_errors++;
      $display("Fail %s: valid expected %b, actual %b", test_name, exp, act);
    end
  endtask

  // compare on the falling edge, then advance the model past the next rising edge
  task automatic check_cycle();
    hazard_req_t req;
    ctrl_mask_t  exp;
    stage_mask_t up;
    @(negedge clk);
    req.ram_mem    = ram_stall_mem;
    req.ram_if     = ram_stall_if;
    req.trap_flush = trap_flush;
    req.trap_stall = trap_stall;
    req.jump       = jump;
    req.muldiv     = muldiv_start || (m_cnt != 0);
    req.load_use   = model_load_use(id_instr, ex_instr, ex_valid);
    req.if_wait    = if_wait;
    exp = model_ctrl(rst, req);
    check_ctrl(exp, ctrl);
    check_valid(m_valid, valid);
    up = {m_valid[`PIPE_STAGES-2:0], fetch_valid};
    if (rst) begin
      m_cnt   = 0;
      m_valid = '0;
    end else begin
      if (muldiv_start && (m_cnt == 0)) begin
        m_cnt = `MULDIV_CYCLES - 1;
      end else if (m_cnt != 0) begin
        m_cnt--;
      end
      for (int k = 0; k < `PIPE_STAGES; k++) begin
        m_valid[k] = exp.flush[k] ? 1'b0 : (exp.stall[k] ? m_valid[k] : up[k]);
      end
    end
  endtask

  task automatic drive_random(input bit reqs, input bit instrs, input bit starts);
    @(posedge clk);
    ram_stall_mem <= reqs && (next_bits(4) == 0);  // 1 in 16
    ram_stall_if  <= reqs && (next_bits(4) == 0);
    trap_flush    <= reqs && (next_bits(4) == 0);
    trap_stall    <= reqs && (next_bits(4) == 0);
    jump          <= reqs && (next_bits(2) == 0);
    if_wait       <= reqs && (next_bits(2) == 0);
    muldiv_start  <= starts && (next_bits(3) == 0);
    fetch_valid   <= (next_bits(2) != 0);
    if (instrs) begin
      ex_valid <= (next_bits(2) != 0);
      id_instr <= rand_instr();
      ex_instr <= rand_instr();
    end
  endtask

  task automatic end_test();
    $display("%s: %0d checks, %0d errors", test_name, t_checks, t_errors);
    tests_run++;
    t_checks = 0;
    t_errors = 0;
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    lfsr          = 16'd12278;
    ram_stall_mem = 1'b0;
    ram_stall_if  = 1'b0;
    trap_flush    = 1'b0;
    trap_stall    = 1'b0;
    jump          = 1'b0;
    if_wait       = 1'b0;
    fetch_valid   = 1'b0;
    muldiv_start  = 1'b0;
    ex_valid      = 1'b0;
    id_instr      = '0;
    ex_instr      = '0;
    m_cnt         = 0;
    m_valid       = '0;

    // reset mask holds against random requests
    // the last pass runs with rst low and an empty pipe
    test_name = "reset";
    check_cycle();
    while (rst) begin
      drive_random(1'b1, 1'b1, 1'b0);
      check_cycle();
    end
    end_test();

    test_name = "muldiv";
    repeat (MD_LEN) begin
      drive_random(1'b0, 1'b0, 1'b1);
      check_cycle();
    end
    end_test();

    test_name = "load_use";
    repeat (LU_LEN) begin
      drive_random(1'b0, 1'b1, 1'b0);
      check_cycle();
    end
    end_test();

    test_name = "random";  // all priority levels plus valid tracking
    repeat (RAND_LEN) begin
      drive_random(1'b1, 1'b1, 1'b1);
      check_cycle();
    end
    end_test();

    $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- build.f
+incdir+rtl
rtl/pipe_ctrl_pkg.sv
rtl/pipe_isa_pkg.sv
rtl/load_use_detect.sv
rtl/muldiv_busy.sv
rtl/pipeline_control.sv
rtl/stage_valid_track.sv
rtl/hazard_top.sv
dv/tb_clk_gen.sv
dv/hazard_props.sv
dv/hazard_tb.sv

//--- Bender.yml
package:
  name: hazard_ctrl

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/pipe_ctrl_pkg.sv
      - rtl/pipe_isa_pkg.sv
      - rtl/load_use_detect.sv
      - rtl/muldiv_busy.sv
      - rtl/pipeline_control.sv
      - rtl/stage_valid_track.sv
      - rtl/hazard_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - dv/tb_clk_gen.sv
      - dv/hazard_props.sv
      - dv/hazard_tb.sv
